//--- verilog/opl_pkg.sv
// opl register map
// addresses, control bit positions, status layout and timer types
// shared by the register file and the timers

package opl_pkg;

    typedef logic [7:0] reg_addr_t;   // register address
    typedef logic [7:0] reg_data_t;   // register data byte
    typedef logic [7:0] timer_val_t;  // timer preset / count
    typedef logic [7:0] status_t;     // status byte

    localparam reg_addr_t ADDR_TIMER1     = 8'h02;
    localparam reg_addr_t ADDR_TIMER2     = 8'h03;
    localparam reg_addr_t ADDR_TIMER_CTRL = 8'h04;

    localparam int CTRL_IRQ_RST = 7;  // irq reset, self clearing
    localparam int CTRL_MT1     = 6;  // mask timer 1
    localparam int CTRL_MT2     = 5;  // mask timer 2
    localparam int CTRL_ST2     = 1;  // start timer 2
    localparam int CTRL_ST1     = 0;  // start timer 1

    localparam int STATUS_IRQ = 7;
    localparam int STATUS_FT1 = 6;
    localparam int STATUS_FT2 = 5;

    localparam timer_val_t TIMER_MAX = 8'hFF;  // overflow point

    localparam int TIMER1_TICK_SAMPLES = 4;   // sample enables per timer 1 tick
    localparam int TIMER2_TICK_SAMPLES = 16;  // sample enables per timer 2 tick

    localparam int PRESCALE_W = $clog2(TIMER2_TICK_SAMPLES);  // wide enough for both
    typedef logic [PRESCALE_W-1:0] prescale_t;

    // last prescaler count per timer, index 0 is timer 1
    localparam logic [1:0][PRESCALE_W-1:0] PRESCALE_LAST = {
        PRESCALE_W'(TIMER2_TICK_SAMPLES - 1),
        PRESCALE_W'(TIMER1_TICK_SAMPLES - 1)
    };

endpackage

//--- verilog/audio_pkg.sv
// audio path definitions
// sample widths, sample rate divider, i2s framing and transmitter states

package audio_pkg;

    localparam int SAMPLE_WIDTH = 16;  // one channel sample
    localparam int DAC_WIDTH    = 24;  // mixed word sent to the dac

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [DAC_WIDTH-1:0]    dac_sample_t;

    localparam int MIX_SHIFT = 7;  // scale 17-bit sum up to 24 bits

    localparam int SAMPLE_DIV   = 256;  // system clocks per sample
    localparam int SAMPLE_DIV_W = $clog2(SAMPLE_DIV);

    localparam int I2S_BIT_CLKS    = 4;   // clocks per bit slot
    localparam int I2S_BIT_W       = $clog2(I2S_BIT_CLKS);
    localparam int I2S_SLOT_BITS   = 32;  // slots per channel half
    localparam int I2S_FRAME_SLOTS = 2 * I2S_SLOT_BITS;
    localparam int I2S_SLOT_W      = $clog2(I2S_FRAME_SLOTS);

    typedef enum logic [1:0] {
        IDLE,   // waiting for a latched sample
        LEFT,   // ws low half
        RIGHT   // ws high half
    } i2s_state_t;

endpackage

//--- verilog/opl_timer_if.sv
// timer settings bundle
// presets, start and mask bits and the irq reset pulse,
// driven by the register file and consumed by the timers

`timescale 1ns/1ps

interface opl_timer_if;

    opl_pkg::timer_val_t timer1;  // timer 1 preset
    opl_pkg::timer_val_t timer2;  // timer 2 preset
    logic                st1;     // run timer 1
    logic                st2;     // run timer 2
    logic                mt1;     // mask timer 1 flag
    logic                mt2;     // mask timer 2 flag
    logic                irq_rst; // one cycle clear of flags and irq

    modport regs (
        output timer1, timer2, st1, st2, mt1, mt2, irq_rst
    );

    modport timers (
        input timer1, timer2, st1, st2, mt1, mt2, irq_rst
    );

endinterface

//--- verilog/sample_clk_div.sv
// sample clock enable
// free running divider, one clock wide pulse every SAMPLE_DIV clocks
// time base for the timers and the i2s transmitter

`timescale 1ns/1ps

module sample_clk_div (
    input  logic clk,
    input  logic rst_n,
    output logic sample_clk_en
);

    logic [audio_pkg::SAMPLE_DIV_W-1:0] div_cnt;  // clock count within one sample

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (div_cnt == audio_pkg::SAMPLE_DIV_W'(audio_pkg::SAMPLE_DIV - 1)) begin
            div_cnt <= '0;  // wrap at terminal count
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // high during the last clock of each sample period
    assign sample_clk_en = (div_cnt == audio_pkg::SAMPLE_DIV_W'(audio_pkg::SAMPLE_DIV - 1));

endmodule

//--- verilog/opl_reg_file.sv
// timer register file
// decodes byte writes to 0x02..0x04 into timer presets and control bits
// irq reset is issued as a single cycle pulse

`timescale 1ns/1ps

module opl_reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              reg_wr,
    input  opl_pkg::reg_addr_t reg_addr,
    input  opl_pkg::reg_data_t reg_data,
    opl_timer_if.regs         tif
);

    opl_pkg::timer_val_t timer1_q;  // timer 1 preset
    opl_pkg::timer_val_t timer2_q;  // timer 2 preset
    logic                st1_q;
    logic                st2_q;
    logic                mt1_q;
    logic                mt2_q;
    logic                irq_rst_q;  // pulse, never held

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer1_q  <= '0;
            timer2_q  <= '0;
            st1_q     <= 1'b0;
            st2_q     <= 1'b0;
            mt1_q     <= 1'b0;
            mt2_q     <= 1'b0;
            irq_rst_q <= 1'b0;
        end else begin
            irq_rst_q <= 1'b0;  // default, drops after one cycle
            if (reg_wr) begin
                case (reg_addr)
                    opl_pkg::ADDR_TIMER1: timer1_q <= opl_pkg::timer_val_t'(reg_data);
                    opl_pkg::ADDR_TIMER2: timer2_q <= opl_pkg::timer_val_t'(reg_data);
                    opl_pkg::ADDR_TIMER_CTRL: begin
                        if (reg_data[opl_pkg::CTRL_IRQ_RST]) begin
                            irq_rst_q <= 1'b1;  // other control bits untouched
                        end else begin
                            st1_q <= reg_data[opl_pkg::CTRL_ST1];
                            st2_q <= reg_data[opl_pkg::CTRL_ST2];
                            mt1_q <= reg_data[opl_pkg::CTRL_MT1];
                            mt2_q <= reg_data[opl_pkg::CTRL_MT2];
                        end
                    end
                    default: ;  // other addresses belong to the synth core
                endcase
            end
        end
    end

    assign tif.timer1  = timer1_q;
    assign tif.timer2  = timer2_q;
    assign tif.st1     = st1_q;
    assign tif.st2     = st2_q;
    assign tif.mt1     = mt1_q;
    assign tif.mt2     = mt2_q;
    assign tif.irq_rst = irq_rst_q;

endmodule

//--- verilog/opl_timers.sv
// opl timers
// two prescaled, loadable 8-bit up-counters with reload on overflow,
// sticky overflow flags, masks, registered irq and the status byte

`timescale 1ns/1ps

module opl_timers (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sample_clk_en,
    opl_timer_if.timers      tif,
    output logic             irq,
    output opl_pkg::status_t status
);

    // index 0 is timer 1, index 1 is timer 2
    logic [1:0]          st;      // run bits
    logic [1:0]          mt;      // mask bits
    logic [1:0]          st_d;    // run bits last cycle, for start detect
    logic [1:0]          tick;    // counter advances this cycle
    logic [1:0]          ovf;     // counter wraps this cycle
    logic [1:0]          ft;      // sticky overflow flags
    logic [1:0]          ft_nxt;
    opl_pkg::timer_val_t preset [2];
    opl_pkg::timer_val_t cnt    [2];
    opl_pkg::prescale_t  pre    [2];  // sample enables within a tick

    assign st        = {tif.st2, tif.st1};
    assign mt        = {tif.mt2, tif.mt1};
    assign preset[0] = tif.timer1;
    assign preset[1] = tif.timer2;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            tick[i] = st[i] && st_d[i] && sample_clk_en
                      && (pre[i] == opl_pkg::PRESCALE_LAST[i]);
            ovf[i]  = tick[i] && (cnt[i] == opl_pkg::TIMER_MAX);
        end
    end

    // masked timers never raise their flag
    assign ft_nxt = tif.irq_rst ? 2'b00 : (ft | (ovf & ~mt));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_d <= 2'b00;
            for (int i = 0; i < 2; i++) begin
                cnt[i] <= '0;
                pre[i] <= '0;
            end
        end else begin
            st_d <= st;
            for (int i = 0; i < 2; i++) begin
                if (st[i] && !st_d[i]) begin
                    cnt[i] <= preset[i];  // start: load preset, restart prescaler
                    pre[i] <= '0;
                end else if (st[i] && sample_clk_en) begin
                    pre[i] <= (pre[i] == opl_pkg::PRESCALE_LAST[i]) ? '0 : pre[i] + 1'b1;
                    if (tick[i]) begin
                        cnt[i] <= ovf[i] ? preset[i] : cnt[i] + 1'b1;  // reload on wrap
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ft  <= 2'b00;
            irq <= 1'b0;
        end else begin
            ft  <= ft_nxt;
            irq <= |(ft_nxt & ~mt);  // lands with the flags
        end
    end

    always_comb begin
        status                      = '0;
        status[opl_pkg::STATUS_IRQ] = irq;
        status[opl_pkg::STATUS_FT1] = ft[0];
        status[opl_pkg::STATUS_FT2] = ft[1];
    end

endmodule

//--- verilog/i2s_tx.sv
// i2s transmitter
// mixes channels a+c and b+d into 24-bit words on the sample enable,
// then sends one 64 slot stereo frame, 4 clocks per slot, msb first

`timescale 1ns/1ps

module i2s_tx (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sample_clk_en,
    input  audio_pkg::sample_t channel_a,
    input  audio_pkg::sample_t channel_b,
    input  audio_pkg::sample_t channel_c,
    input  audio_pkg::sample_t channel_d,
    output logic               i2s_sclk,
    output logic               i2s_ws,
    output logic               i2s_sd
);

    audio_pkg::i2s_state_t                state;
    logic [audio_pkg::I2S_BIT_W-1:0]      bit_cnt;   // clock within slot
    logic [audio_pkg::I2S_SLOT_W-1:0]     slot;      // slot within frame
    logic [audio_pkg::I2S_SLOT_W-2:0]     half_pos;  // slot within channel half
    audio_pkg::dac_sample_t               mix_l;
    audio_pkg::dac_sample_t               mix_r;
    audio_pkg::dac_sample_t               hold_l;    // next words, wait for frame start
    audio_pkg::dac_sample_t               hold_r;
    audio_pkg::dac_sample_t               tx_sh;     // word being shifted out
    logic                                 start_pend;
    logic                                 start_go;
    logic                                 slot_end;
    logic                                 half_end;
    logic                                 frame_end;
    logic                                 data_slot;

    // sign extend before the add so negative sums survive
    assign mix_l = (audio_pkg::dac_sample_t'(channel_a) + audio_pkg::dac_sample_t'(channel_c))
                   <<< audio_pkg::MIX_SHIFT;
    assign mix_r = (audio_pkg::dac_sample_t'(channel_b) + audio_pkg::dac_sample_t'(channel_d))
                   <<< audio_pkg::MIX_SHIFT;

    assign half_pos  = slot[audio_pkg::I2S_SLOT_W-2:0];
    assign slot_end  = (bit_cnt == audio_pkg::I2S_BIT_W'(audio_pkg::I2S_BIT_CLKS - 1));
    assign half_end  = slot_end && (half_pos == '1);
    assign frame_end = half_end && (state == audio_pkg::RIGHT);
    assign start_go  = start_pend && ((state == audio_pkg::IDLE) || frame_end);
    // slot 0 of each half is the one bit delay, then 24 data slots
    assign data_slot = (half_pos != '0) && (int'(half_pos) <= audio_pkg::DAC_WIDTH);

    always_ff @(posedge clk) begin
        if (sample_clk_en) begin
            hold_l <= mix_l;
            hold_r <= mix_r;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_pend <= 1'b0;
        end else begin
            if (start_go)
                start_pend <= 1'b0;
            if (sample_clk_en)
                start_pend <= 1'b1;  // new words waiting
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= audio_pkg::IDLE;
            bit_cnt <= '0;
            slot    <= '0;
        end else if (start_go) begin
            state   <= audio_pkg::LEFT;
            bit_cnt <= '0;
            slot    <= '0;
        end else if (state != audio_pkg::IDLE) begin
            bit_cnt <= slot_end ? '0 : bit_cnt + 1'b1;
            if (slot_end)
                slot <= slot + 1'b1;  // wraps to 0 at frame end
            if (half_end)
                state <= (state == audio_pkg::LEFT) ? audio_pkg::RIGHT : audio_pkg::IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (start_go)
            tx_sh <= hold_l;
        else if (half_end && (state == audio_pkg::LEFT))
            tx_sh <= hold_r;  // swap in right word at ws edge
        else if (slot_end && data_slot)
            tx_sh <= tx_sh << 1;
    end

    // sclk low for first half of the slot, high for second half
    assign i2s_sclk = (state != audio_pkg::IDLE)
                      && (bit_cnt >= audio_pkg::I2S_BIT_W'(audio_pkg::I2S_BIT_CLKS / 2));
    assign i2s_ws   = (state == audio_pkg::RIGHT);
    assign i2s_sd   = (state != audio_pkg::IDLE) && data_slot
                      && tx_sh[audio_pkg::DAC_WIDTH-1];

endmodule

//--- verilog/opl_core.sv
// opl sound output and timer core
// register write port, sample time base, chip timers with irq/status,
// and stereo mix of four channel samples out over i2s

`timescale 1ns/1ps

module opl_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               reg_wr,     // one cycle write strobe
    input  opl_pkg::reg_addr_t reg_addr,
    input  opl_pkg::reg_data_t reg_data,
    input  audio_pkg::sample_t channel_a,
    input  audio_pkg::sample_t channel_b,
    input  audio_pkg::sample_t channel_c,
    input  audio_pkg::sample_t channel_d,
    output logic               irq,
    output opl_pkg::status_t   status,
    output logic               i2s_sclk,
    output logic               i2s_ws,
    output logic               i2s_sd
);

    logic sample_clk_en;  // one pulse per sample period

    opl_timer_if tif ();

    sample_clk_div u_sample_clk_div (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en)
    );

    opl_reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_wr   (reg_wr),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .tif      (tif.regs)
    );

    opl_timers u_timers (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .tif           (tif.timers),
        .irq           (irq),
        .status        (status)
    );

    i2s_tx u_i2s_tx (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .channel_a     (channel_a),
        .channel_b     (channel_b),
        .channel_c     (channel_c),
        .channel_d     (channel_d),
        .i2s_sclk      (i2s_sclk),
        .i2s_ws        (i2s_ws),
        .i2s_sd        (i2s_sd)
    );

endmodule

//--- tb/opl_core_assert.sv
// opl core runtime checks
// irq/status agreement, sample enable width, i2s word select timing
// and back to back i2s frames

`timescale 1ns/1ps

module opl_core_assert (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  irq,
    input opl_pkg::status_t      status,
    input logic                  sample_clk_en,
    input logic                  i2s_sclk,
    input logic                  i2s_ws,
    input audio_pkg::i2s_state_t tx_state
);

    // irq needs its status bit and at least one raised flag
    irq_in_status: assert property (@(posedge clk) disable iff (!rst_n)
        irq |-> (status[opl_pkg::STATUS_IRQ]
                 && (status[opl_pkg::STATUS_FT1] || status[opl_pkg::STATUS_FT2])))
        else $error("irq high without status irq bit and a timer flag");

    en_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        sample_clk_en |=> !sample_clk_en)
        else $error("sample enable held for two cycles");

    // ws moves only at a slot start where sclk has just dropped
    ws_at_slot_start: assert property (@(posedge clk) disable iff (!rst_n)
        (i2s_ws != $past(i2s_ws)) |-> (!i2s_sclk && $past(i2s_sclk)))
        else $error("word select changed away from a slot boundary");

    // frame length matches the sample period so frames run back to back
    no_idle_gap: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_state != audio_pkg::IDLE) |=> (tx_state != audio_pkg::IDLE))
        else $error("i2s transmitter fell back to idle between frames");

endmodule

bind opl_core opl_core_assert u_core_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .irq           (irq),
    .status        (status),
    .sample_clk_en (sample_clk_en),
    .i2s_sclk      (i2s_sclk),
    .i2s_ws        (i2s_ws),
    .tx_state      (u_i2s_tx.state)
);

//--- tb/tb_opl_core.sv
// opl core testbench
// directed tests for reset, i2s frames, timer overflow, irq reset and masking

`timescale 1ns/1ps

module tb_opl_core;

    localparam int CLK_PERIOD = 4;
    localparam int T1_SPAN  = 3 * 1 * opl_pkg::TIMER1_TICK_SAMPLES * audio_pkg::SAMPLE_DIV;
    localparam int T2_SPAN  = 3 * 2 * opl_pkg::TIMER2_TICK_SAMPLES * audio_pkg::SAMPLE_DIV;
    localparam int IRQ_HOLD = 2 * opl_pkg::TIMER1_TICK_SAMPLES * audio_pkg::SAMPLE_DIV;
    localparam int TEST_CLKS = 8 + 3 * 4 * audio_pkg::SAMPLE_DIV + T1_SPAN + IRQ_HOLD
                               + 2 * T2_SPAN;
    localparam int WATCHDOG_CLKS = 2 * TEST_CLKS;

    logic               clk;
    logic               rst_n;
    logic               reg_wr;
    opl_pkg::reg_addr_t reg_addr;
    opl_pkg::reg_data_t reg_data;
    audio_pkg::sample_t channel_a, channel_b, channel_c, channel_d;
    logic               irq;
    opl_pkg::status_t   status;
    logic               i2s_sclk, i2s_ws, i2s_sd;
    int                 seed;

    opl_core uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CLKS * CLK_PERIOD);
        fail_stop("watchdog expired, the tests ran too long");
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            fail_stop("value mismatch");
        end
    endtask

    // called on a falling edge, returns one cycle later
    task automatic write_reg(input opl_pkg::reg_addr_t addr, input opl_pkg::reg_data_t data);
        reg_wr   = 1'b1;
        reg_addr = addr;
        reg_data = data;
        @(negedge clk);
        reg_wr   = 1'b0;
    endtask

    task automatic wait_irq(input string name, input int max_clks);
        int n;
        n = 0;
        while (irq !== 1'b1) begin
            if (n >= max_clks)
                fail_stop($sformatf("%s: irq did not rise within %0d clocks", name, max_clks));
            @(negedge clk);
            n++;
        end
    endtask

    task automatic check_quiet(input string name, input int clks);
        for (int n = 0; n < clks; n++) begin
            @(negedge clk);
            check(name, 64'h0, 64'({irq, status}));
        end
    endtask

    task automatic wait_ws_fall();
        int   n;
        logic prev;
        n = 0;
        do begin
            prev = i2s_ws;
            @(negedge clk);
            n++;
            if (n > 3 * audio_pkg::SAMPLE_DIV)
                fail_stop("timeout waiting for the i2s word select to fall");
        end while (!(prev && !i2s_ws));
    endtask

    // one bit per sclk rise with slot 0 in bit 63
    task automatic capture_frame(output logic [63:0] sd_bits, output logic [63:0] ws_bits);
        int   n;
        int   gap;
        logic prev_sclk;
        wait_ws_fall();
        n         = 0;
        gap       = 0;
        prev_sclk = i2s_sclk;
        sd_bits   = '0;
        ws_bits   = '0;
        while (n < audio_pkg::I2S_FRAME_SLOTS) begin
            @(negedge clk);
            gap++;
            if (gap > 2 * audio_pkg::I2S_BIT_CLKS)
                fail_stop("timeout waiting for the i2s bit clock to rise");
            if (i2s_sclk && !prev_sclk) begin
                if (n > 0)
                    check("i2s bit clock period", 64'(audio_pkg::I2S_BIT_CLKS), 64'(gap));
                sd_bits = {sd_bits[62:0], i2s_sd};
                ws_bits = {ws_bits[62:0], i2s_ws};
                gap     = 0;
                n++;
            end
            prev_sclk = i2s_sclk;
        end
    endtask

    task automatic test_reset_values();
        check("reset values", 64'h0, 64'({irq, status, i2s_sclk, i2s_ws, i2s_sd}));
    endtask

    task automatic test_i2s_frames();
        int          sum_l;
        int          sum_r;
        logic [23:0] exp_l;
        logic [23:0] exp_r;
        logic [63:0] sd_bits;
        logic [63:0] ws_bits;
        for (int i = 0; i < 3; i++) begin
            channel_a = audio_pkg::sample_t'($random(seed));
            channel_b = audio_pkg::sample_t'($random(seed));
            channel_c = audio_pkg::sample_t'($random(seed));
            channel_d = audio_pkg::sample_t'($random(seed));
            if (i == 1) begin
                channel_a[15] = 1'b1;  // negative left sum
                channel_c[15] = 1'b1;
            end
            if (i == 2) begin
                channel_b[15] = 1'b1;  // negative right sum
                channel_d[15] = 1'b1;
            end
            sum_l = int'(channel_a) + int'(channel_c);
            sum_r = int'(channel_b) + int'(channel_d);
            exp_l = 24'(sum_l * (1 << audio_pkg::MIX_SHIFT));
            exp_r = 24'(sum_r * (1 << audio_pkg::MIX_SHIFT));
            wait_ws_fall();  // frame may still hold old words
            capture_frame(sd_bits, ws_bits);
            check("i2s frame data", {1'b0, exp_l, 7'b0, 1'b0, exp_r, 7'b0}, sd_bits);
            check("i2s word select", {32'h0, 32'hFFFF_FFFF}, ws_bits);
        end
    endtask

    task automatic test_timer1_overflow();
        write_reg(opl_pkg::ADDR_TIMER1, 8'hFF);
        write_reg(opl_pkg::ADDR_TIMER_CTRL, 8'h01);  // st1
        wait_irq("timer1 overflow", T1_SPAN);
        check("timer1 overflow", 64'hC0, 64'(status));
    endtask

    task automatic test_irq_reset();
        write_reg(opl_pkg::ADDR_TIMER_CTRL, 8'h00);  // stop timer 1
        write_reg(opl_pkg::ADDR_TIMER_CTRL, 8'h80);
        @(negedge clk);  // flags clear one cycle after the pulse
        check("irq reset", 64'h0, 64'({irq, status}));
        check_quiet("irq reset hold", IRQ_HOLD);
    endtask

    task automatic test_timer2_mask();
        write_reg(opl_pkg::ADDR_TIMER2, 8'hFE);
        write_reg(opl_pkg::ADDR_TIMER_CTRL, 8'h42);  // st2, mt1
        wait_irq("timer2 overflow", T2_SPAN);
        check("timer2 overflow", 64'hA0, 64'(status));
        write_reg(opl_pkg::ADDR_TIMER_CTRL, 8'h80);
        write_reg(opl_pkg::ADDR_TIMER_CTRL, 8'h22);  // st2, mt2
        check_quiet("timer2 masked", T2_SPAN);
    endtask

    initial begin
        seed      = 32'h4056;
        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_data  = '0;
        channel_a = '0;
        channel_b = '0;
        channel_c = '0;
        channel_d = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_values();
        test_i2s_frames();
        test_timer1_overflow();
        test_irq_reset();
        test_timer2_mask();
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- filelist.f
verilog/opl_pkg.sv
verilog/audio_pkg.sv
verilog/opl_timer_if.sv
verilog/sample_clk_div.sv
verilog/opl_reg_file.sv
verilog/opl_timers.sv
verilog/i2s_tx.sv
verilog/opl_core.sv
tb/opl_core_assert.sv
tb/tb_opl_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the opl core testbench with verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_opl_core -f filelist.f -o sim_opl_core &&
./obj_dir/sim_opl_core &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
